// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/10ps
TOP       ?= exec_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "FAIL: pass line not found in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+src
+incdir+verification
src/exec_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/exec_pipe.sv
src/exec_top.sv
verification/exec_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/10ps
`include "exec_defines.svh"

module alu (
  input  exec_pkg::alu_ctl_t    ctl,
  input  exec_pkg::status_t     status_in,
  input  logic [`EXEC_XLEN-1:0] opnd0,
  input  logic [`EXEC_XLEN-1:0] opnd1,
  output logic [`EXEC_XLEN-1:0] result,
  output exec_pkg::status_t     status_out,
  output logic                  wr_result
);

  import exec_pkg::*;

  logic [`EXEC_XLEN-1:0] b_inv;    // operand 1 after inversion
  logic [`EXEC_XLEN-1:0] b_mod;    // operand 1 after increment
  logic                  carry_in;
  logic [`EXEC_XLEN:0]   a_ext;
  logic [`EXEC_XLEN:0]   b_ext;
  logic [`EXEC_XLEN:0]   s_div;
  logic [`EXEC_XLEN:0]   s;        // 33-bit raw result

  assign b_inv = ctl.src_inv ? ~opnd1 : opnd1;
  assign b_mod = ctl.src_inc ? b_inv + 1'b1 : b_inv;

  assign carry_in = ctl.use_carry & status_in.cf;  // both must be set

  assign a_ext = {1'b0, opnd0};
  assign b_ext = {1'b0, b_mod};

  // divide by zero gives all ones with bit 32 clear
  assign s_div = (b_mod == '0) ? {1'b0, {`EXEC_XLEN{1'b1}}} : a_ext / b_ext;

  always_comb begin
    s = '0;
    case (ctl.op)
      op_add:             s = a_ext + b_ext + {{`EXEC_XLEN{1'b0}}, carry_in};
      op_sub:             s = a_ext - b_ext + {{`EXEC_XLEN{1'b0}}, carry_in};
      op_and:             s = a_ext & b_ext;
      op_or:              s = a_ext | b_ext;
      op_xor:             s = a_ext ^ b_ext;
      op_mul:             s = a_ext * b_ext;  // low 33 bits of the product
      op_div, op_div_alt: s = s_div;
    endcase
  end

  assign wr_result = ~ctl.no_wr;
  assign result    = ctl.no_wr ? '0 : s[`EXEC_XLEN-1:0];

  always_comb begin
    if (ctl.no_wr) begin
      status_out = status_in;  // every flag held
    end else begin
      status_out.cf = ctl.clear_cf ? 1'b0 : s[`EXEC_XLEN];
      status_out.pf = ~^s[`EXEC_XLEN-1:0];            // even parity
      status_out.zf = (s[`EXEC_XLEN-1:0] == '0);
      status_out.sf = s[`EXEC_XLEN-1];
      // both input signs xor the result sign rather than a true signed overflow
      status_out.of = ctl.clear_of ? 1'b0 :
                      (opnd0[`EXEC_XLEN-1] & b_mod[`EXEC_XLEN-1]) ^ s[`EXEC_XLEN-1];
    end
  end

endmodule

// ==== src/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

`define EXEC_XLEN    32  // datapath width
`define EXEC_NREGS   16  // register file depth
`define EXEC_REG_AW  4   // register index width
`define EXEC_IMM_W   14  // immediate width before zero extension

// instruction word layout
`define EXEC_F_OP_HI      31
`define EXEC_F_OP_LO      29
`define EXEC_F_IMM_SEL    28
`define EXEC_F_USE_CARRY  27
`define EXEC_F_NO_WR      26
`define EXEC_F_CLEAR_CF   25
`define EXEC_F_CLEAR_OF   24
`define EXEC_F_SRC_INV    23
`define EXEC_F_SRC_INC    22
`define EXEC_F_RD_HI      21
`define EXEC_F_RD_LO      18
`define EXEC_F_RS0_HI     17
`define EXEC_F_RS0_LO     14
`define EXEC_F_RS1_HI     13
`define EXEC_F_RS1_LO     10
`define EXEC_F_IMM_HI     13
`define EXEC_F_IMM_LO     0

`endif

// ==== src/exec_pipe.sv ====
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_pipe (
  input  logic                    clk,
  input  logic                    reset,

  input  logic                    in_valid,
  output logic                    in_ready,
  input  exec_pkg::dec_instr_t    dec,

  output logic                    out_valid,
  input  logic                    out_ready,
  output exec_pkg::exec_rsp_t     rsp,

  output logic [`EXEC_REG_AW-1:0] raddr0,
  output logic [`EXEC_REG_AW-1:0] raddr1,
  input  logic [`EXEC_XLEN-1:0]   rdata0,
  input  logic [`EXEC_XLEN-1:0]   rdata1,

  output exec_pkg::alu_ctl_t      alu_ctl,
  output logic [`EXEC_XLEN-1:0]   alu_opnd0,
  output logic [`EXEC_XLEN-1:0]   alu_opnd1,
  output exec_pkg::status_t       alu_status,
  input  logic [`EXEC_XLEN-1:0]   alu_result,
  input  exec_pkg::status_t       alu_status_out,
  input  logic                    alu_wr,

  output logic                    rf_we,
  output logic [`EXEC_REG_AW-1:0] rf_waddr,
  output logic [`EXEC_XLEN-1:0]   rf_wdata
);

  import exec_pkg::*;

  logic       s1_valid;  // stage 1 occupied
  dec_instr_t s1_dec;    // stage 1 payload
  status_t    status_q;  // architectural flags
  exec_rsp_t  rsp_q;     // output register payload
  logic       in_fire;
  logic       out_fire;
  logic       s1_move;   // stage 1 advances into the output register

  assign out_fire = out_valid & out_ready;
  assign s1_move  = s1_valid & (~out_valid | out_ready);
  assign in_ready = ~s1_valid | s1_move;
  assign in_fire  = in_valid & in_ready;

  // stage 1 entry
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (in_fire) begin
      s1_valid <= 1'b1;
    end else if (s1_move) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      s1_dec <= dec;
    end
  end

  // operand fetch from stage 1, writes of older instructions are already done
  assign raddr0 = s1_dec.rs0;
  assign raddr1 = s1_dec.rs1;

  assign alu_ctl    = s1_dec.ctl;
  assign alu_opnd0  = rdata0;
  assign alu_opnd1  = s1_dec.imm_sel ?
                      {{(`EXEC_XLEN-`EXEC_IMM_W){1'b0}}, s1_dec.imm} : rdata1;
  assign alu_status = status_q;

  // writeback happens on the same edge as the move
  assign rf_we    = s1_move & alu_wr;
  assign rf_waddr = s1_dec.rd;
  assign rf_wdata = alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      status_q <= '0;
    end else if (s1_move) begin
      status_q <= alu_status_out;  // alu already holds flags under no_wr
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (s1_move) begin
      out_valid <= 1'b1;
    end else if (out_fire) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_move) begin
      rsp_q.result <= alu_result;
      rsp_q.status <= alu_status_out;
      rsp_q.rd     <= s1_dec.rd;
      rsp_q.wrote  <= alu_wr;
    end
  end

  assign rsp = rsp_q;

endmodule

// ==== src/exec_pkg.sv ====
`include "exec_defines.svh"

package exec_pkg;

  typedef enum logic [2:0] {
    op_add     = 3'd0,
    op_sub     = 3'd1,
    op_and     = 3'd2,
    op_or      = 3'd3,
    op_xor     = 3'd4,
    op_mul     = 3'd5,
    op_div     = 3'd6,
    op_div_alt = 3'd7  // decodes as divide
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    logic    use_carry;  // add cf into the sum when cf is set
    logic    no_wr;      // zero result, hold flags
    logic    clear_cf;
    logic    clear_of;
    logic    src_inv;    // invert operand 1
    logic    src_inc;    // increment operand 1 after inversion
  } alu_ctl_t;

  typedef struct packed {
    logic cf;
    logic pf;
    logic zf;
    logic sf;
    logic of;
  } status_t;

  typedef struct packed {
    alu_ctl_t                ctl;
    logic [`EXEC_REG_AW-1:0] rd;
    logic [`EXEC_REG_AW-1:0] rs0;
    logic [`EXEC_REG_AW-1:0] rs1;
    logic                    imm_sel;  // operand 1 from immediate
    logic [`EXEC_IMM_W-1:0]  imm;
  } dec_instr_t;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0]   result;
    status_t                 status;
    logic [`EXEC_REG_AW-1:0] rd;
    logic                    wrote;  // register file written
  } exec_rsp_t;

endpackage

// ==== src/exec_top.sv ====
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [`EXEC_XLEN-1:0] instr,
  output logic                  out_valid,
  input  logic                  out_ready,
  output exec_pkg::exec_rsp_t   rsp
);

  import exec_pkg::*;

  dec_instr_t              dec;
  logic [`EXEC_REG_AW-1:0] raddr0;
  logic [`EXEC_REG_AW-1:0] raddr1;
  logic [`EXEC_XLEN-1:0]   rdata0;
  logic [`EXEC_XLEN-1:0]   rdata1;
  alu_ctl_t                alu_ctl;
  logic [`EXEC_XLEN-1:0]   alu_opnd0;
  logic [`EXEC_XLEN-1:0]   alu_opnd1;
  status_t                 alu_status;
  logic [`EXEC_XLEN-1:0]   alu_result;
  status_t                 alu_status_out;
  logic                    alu_wr;
  logic                    rf_we;
  logic [`EXEC_REG_AW-1:0] rf_waddr;
  logic [`EXEC_XLEN-1:0]   rf_wdata;

  instr_decoder decoder_i (
    .instr (instr),
    .dec   (dec)
  );

  exec_pipe pipe_i (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .dec            (dec),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .rsp            (rsp),
    .raddr0         (raddr0),
    .raddr1         (raddr1),
    .rdata0         (rdata0),
    .rdata1         (rdata1),
    .alu_ctl        (alu_ctl),
    .alu_opnd0      (alu_opnd0),
    .alu_opnd1      (alu_opnd1),
    .alu_status     (alu_status),
    .alu_result     (alu_result),
    .alu_status_out (alu_status_out),
    .alu_wr         (alu_wr),
    .rf_we          (rf_we),
    .rf_waddr       (rf_waddr),
    .rf_wdata       (rf_wdata)
  );

  reg_file rf_i (
    .clk    (clk),
    .reset  (reset),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  alu alu_i (
    .ctl        (alu_ctl),
    .status_in  (alu_status),
    .opnd0      (alu_opnd0),
    .opnd1      (alu_opnd1),
    .result     (alu_result),
    .status_out (alu_status_out),
    .wr_result  (alu_wr)
  );

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/10ps
`include "exec_defines.svh"

module instr_decoder (
  input  logic [`EXEC_XLEN-1:0] instr,
  output exec_pkg::dec_instr_t  dec
);

  import exec_pkg::*;

  alu_ctl_t ctl;  // control fields of the word

  always_comb begin
    ctl.op        = alu_op_e'(instr[`EXEC_F_OP_HI:`EXEC_F_OP_LO]);
    ctl.use_carry = instr[`EXEC_F_USE_CARRY];
    ctl.no_wr     = instr[`EXEC_F_NO_WR];
    ctl.clear_cf  = instr[`EXEC_F_CLEAR_CF];
    ctl.clear_of  = instr[`EXEC_F_CLEAR_OF];
    ctl.src_inv   = instr[`EXEC_F_SRC_INV];
    ctl.src_inc   = instr[`EXEC_F_SRC_INC];
  end

  // rs1 and the immediate overlap, the pipe picks one by imm_sel
  always_comb begin
    dec.ctl     = ctl;
    dec.rd      = instr[`EXEC_F_RD_HI:`EXEC_F_RD_LO];
    dec.rs0     = instr[`EXEC_F_RS0_HI:`EXEC_F_RS0_LO];
    dec.rs1     = instr[`EXEC_F_RS1_HI:`EXEC_F_RS1_LO];
    dec.imm_sel = instr[`EXEC_F_IMM_SEL];
    dec.imm     = instr[`EXEC_F_IMM_HI:`EXEC_F_IMM_LO];  // kept at 14 bits
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/10ps
`include "exec_defines.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`EXEC_REG_AW-1:0] raddr0,
  input  logic [`EXEC_REG_AW-1:0] raddr1,
  output logic [`EXEC_XLEN-1:0]   rdata0,
  output logic [`EXEC_XLEN-1:0]   rdata1,
  input  logic                    we,
  input  logic [`EXEC_REG_AW-1:0] waddr,
  input  logic [`EXEC_XLEN-1:0]   wdata
);

  logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        regs[i] <= '0;  // architectural state starts at zero
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads, no bypass needed
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

endmodule

// ==== verification/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// architectural state as the program sees it
logic [`EXEC_XLEN-1:0] model_regs [`EXEC_NREGS];
status_t               model_status;

function automatic void model_reset();
  for (int i = 0; i < `EXEC_NREGS; i++) begin
    model_regs[i] = '0;
  end
  model_status = '0;
endfunction

// runs one instruction word on the model state, returns the response it should give
function automatic exec_rsp_t model_execute(input logic [`EXEC_XLEN-1:0] word);
  alu_op_e                 op;
  logic [`EXEC_REG_AW-1:0] rd;
  logic [`EXEC_XLEN-1:0]   a;
  logic [`EXEC_XLEN-1:0]   b;
  logic                    c;
  logic [`EXEC_XLEN:0]     s;
  logic [2*`EXEC_XLEN-1:0] prod;
  exec_rsp_t               want;
  op = alu_op_e'(word[`EXEC_F_OP_HI:`EXEC_F_OP_LO]);
  rd = word[`EXEC_F_RD_HI:`EXEC_F_RD_LO];
  a  = model_regs[word[`EXEC_F_RS0_HI:`EXEC_F_RS0_LO]];
  b  = '0;
  if (word[`EXEC_F_IMM_SEL]) begin
    b[`EXEC_IMM_W-1:0] = word[`EXEC_F_IMM_HI:`EXEC_F_IMM_LO];  // zero extended
  end else begin
    b = model_regs[word[`EXEC_F_RS1_HI:`EXEC_F_RS1_LO]];
  end
  if (word[`EXEC_F_SRC_INV]) b = ~b;
  if (word[`EXEC_F_SRC_INC]) b = b + 32'd1;  // increment comes after inversion
  c    = word[`EXEC_F_USE_CARRY] & model_status.cf;
  s    = '0;
  prod = '0;
  case (op)
    op_add: s = {1'b0, a} + {1'b0, b} + {{`EXEC_XLEN{1'b0}}, c};
    op_sub: s = {1'b0, a} - {1'b0, b} + {{`EXEC_XLEN{1'b0}}, c};
    op_and: s = {1'b0, a & b};
    op_or:  s = {1'b0, a | b};
    op_xor: s = {1'b0, a ^ b};
    op_mul: begin
      prod = {{`EXEC_XLEN{1'b0}}, a} * {{`EXEC_XLEN{1'b0}}, b};
      s    = prod[`EXEC_XLEN:0];
    end
    op_div, op_div_alt: begin
      if (b == '0) s = {1'b0, {`EXEC_XLEN{1'b1}}};  // divide by zero
      else s = {1'b0, a / b};
    end
  endcase
  want.rd    = rd;
  want.wrote = ~word[`EXEC_F_NO_WR];
  if (word[`EXEC_F_NO_WR]) begin
    want.result = '0;  // flags and rd untouched
  end else begin
    want.result     = s[`EXEC_XLEN-1:0];
    model_status.cf = word[`EXEC_F_CLEAR_CF] ? 1'b0 : s[`EXEC_XLEN];
    model_status.pf = ~^s[`EXEC_XLEN-1:0];
    model_status.zf = (s[`EXEC_XLEN-1:0] == '0);
    model_status.sf = s[`EXEC_XLEN-1];
    model_status.of = word[`EXEC_F_CLEAR_OF] ? 1'b0 :
                      (a[`EXEC_XLEN-1] & b[`EXEC_XLEN-1]) ^ s[`EXEC_XLEN-1];
    model_regs[rd]  = s[`EXEC_XLEN-1:0];
  end
  want.status = model_status;
  return want;
endfunction

`endif

// ==== verification/exec_tb.sv ====
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_tb;

  import exec_pkg::*;

  localparam int NUM_INSTR  = 400;
  localparam int MAX_CYCLES = NUM_INSTR * 20 + 100;

  logic                  clk;
  logic                  reset;
  logic                  in_valid;
  logic                  in_ready;
  logic [`EXEC_XLEN-1:0] instr;
  logic                  out_valid;
  logic                  out_ready;
  exec_rsp_t             rsp;

  logic [31:0] rng_state = 32'd67;
  logic [31:0] coin;           // handshake draw for this cycle
  exec_rsp_t   exp_q [$];      // expected responses in issue order
  int          issued      = 0;
  int          rsp_count   = 0;
  int          cycle_count = 0;

  `include "exec_model.svh"

  exec_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .rsp       (rsp)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [`EXEC_XLEN-1:0] build_instr();
    logic [`EXEC_XLEN-1:0] w;
    logic [31:0]           r;
    w = next_random();
    r = next_random();
    w[`EXEC_F_IMM_SEL] = r[0];                // about half immediates
    w[`EXEC_F_NO_WR]   = (r[3:1] == 3'b000);  // about one in eight
    if (r[6:4] == 3'b000) begin
      w[`EXEC_F_IMM_HI:`EXEC_F_IMM_LO] = '0;  // zero immediate, rs1 = r0
    end
    return w;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, want);
      $display("sim failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_response();
    exec_rsp_t want;
    if (exp_q.size() == 0) begin
      $display("error at %0t ns: response with no instruction outstanding", $time);
      $display("sim failed");
      $fatal(1, "unexpected response");
    end else begin
      want = exp_q.pop_front();
      check_equal($sformatf("rsp %0d result", rsp_count), rsp.result, want.result);
      check_equal($sformatf("rsp %0d cf", rsp_count), 32'(rsp.status.cf), 32'(want.status.cf));
      check_equal($sformatf("rsp %0d pf", rsp_count), 32'(rsp.status.pf), 32'(want.status.pf));
      check_equal($sformatf("rsp %0d zf", rsp_count), 32'(rsp.status.zf), 32'(want.status.zf));
      check_equal($sformatf("rsp %0d sf", rsp_count), 32'(rsp.status.sf), 32'(want.status.sf));
      check_equal($sformatf("rsp %0d of", rsp_count), 32'(rsp.status.of), 32'(want.status.of));
      check_equal($sformatf("rsp %0d rd", rsp_count), 32'(rsp.rd), 32'(want.rd));
      check_equal($sformatf("rsp %0d wrote", rsp_count), 32'(rsp.wrote), 32'(want.wrote));
      rsp_count++;
    end
  endtask

  // both handshakes and the scoreboard share one process so the draws stay ordered
  always @(posedge clk) begin
    if (reset) begin
      in_valid  <= 1'b0;
      out_ready <= 1'b0;
    end else begin
      coin = next_random();
      if (out_valid && out_ready) begin
        check_response();
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(model_execute(instr));
      end
      if (!in_valid || in_ready) begin  // slot free, payload may change
        if (issued < NUM_INSTR && coin[1:0] != 2'b00) begin
          in_valid <= 1'b1;
          instr    <= build_instr();
          issued++;
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= (coin[3:2] != 2'b00);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d responses", cycle_count,
               rsp_count, NUM_INSTR);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    instr     = '0;
    model_reset();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    wait (rsp_count == NUM_INSTR);
    repeat (10) @(posedge clk);  // catch any stray extra response
    if (exp_q.size() == 0 && rsp_count == NUM_INSTR) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("end of run with %0d responses and %0d still expected", rsp_count,
               exp_q.size());
      $display("sim failed");
      $fatal(1, "end of run check");
    end
  end

endmodule
